// ==== include/mips_defines.svh ====
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// Machine word and storage sizes
`define DATA_WIDTH     32
`define REG_ADDR_WIDTH 5
`define IMEM_DEPTH     64 // Instruction words
`define DMEM_DEPTH     64 // Data words

// Primary opcodes
`define OP_RTYPE 6'b000000
`define OP_LW    6'b100011
`define OP_SW    6'b101011
`define OP_BEQ   6'b000100
`define OP_ADDI  6'b001000

// R-type funct codes
`define FN_ADD 6'b100000
`define FN_SUB 6'b100010
`define FN_AND 6'b100100
`define FN_OR  6'b100101
`define FN_SLT 6'b101010

`endif

// ==== logic/mips_pkg.sv ====
package mips_pkg;

	// R-type layout
	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt; // Unused, no shifts
		logic [5:0] funct;
	} r_fmt_t;

	// I-type layout
	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
	} i_fmt_t;

	// One instruction word, two views
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
	} instr_t;

	// ALU operation select
	// Classic MIPS ALU control codes
	typedef enum logic [3:0] {
		ALU_AND = 4'b0000,
		ALU_OR  = 4'b0001,
		ALU_ADD = 4'b0010,
		ALU_SUB = 4'b0110,
		ALU_SLT = 4'b0111
	} alu_op_t;

	// Main decoder to function decoder
	typedef enum logic [1:0] {
		CLS_ADD   = 2'b00, // lw, sw, addi
		CLS_SUB   = 2'b01, // beq compare
		CLS_FUNCT = 2'b10  // R-type, look at funct
	} alu_class_t;

endpackage

// ==== logic/ctrl_if.sv ====
interface ctrl_if;

	logic reg_dst;    // Destination from rd
	logic branch;     // beq
	logic mem_read;
	logic mem_to_reg; // Write back from memory
	logic mem_write;
	logic alu_src;    // Second operand is immediate
	logic reg_write;
	mips_pkg::alu_op_t alu_op;

	// Decoder side
	modport ctrl (
		output reg_dst, branch, mem_read, mem_to_reg,
		output mem_write, alu_src, reg_write, alu_op
	);

	// Datapath side
	modport dp (
		input reg_dst, branch, mem_read, mem_to_reg,
		input mem_write, alu_src, reg_write, alu_op
	);

endinterface

// ==== logic/alu.sv ====
`include "mips_defines.svh"

module alu (
	input  logic [`DATA_WIDTH-1:0] a,
	input  logic [`DATA_WIDTH-1:0] b,
	ctrl_if.dp                     cs,
	output logic [`DATA_WIDTH-1:0] result,
	output logic                   zero
);

	logic [`DATA_WIDTH-1:0] sum;
	logic [`DATA_WIDTH-1:0] diff;
	logic                   less; // Signed compare

	assign sum  = a + b;
	assign diff = a - b;
	assign less = $signed(a) < $signed(b);

	always_comb begin
		case (cs.alu_op)
			mips_pkg::ALU_AND: result = a & b;
			mips_pkg::ALU_OR:  result = a | b;
			mips_pkg::ALU_ADD: result = sum;
			mips_pkg::ALU_SUB: result = diff;
			mips_pkg::ALU_SLT: result = {{(`DATA_WIDTH-1){1'b0}}, less};
			default:           result = '0;
		endcase
	end

	// Drives the beq decision
	assign zero = (result == '0);

endmodule

// ==== logic/control.sv ====
`include "mips_defines.svh"

module control (
	input  mips_pkg::instr_t instr,
	ctrl_if.ctrl             cs
);

	mips_pkg::alu_class_t alu_class;

	// Main decoder on the opcode
	always_comb begin
		cs.reg_dst    = 1'b0;
		cs.branch     = 1'b0;
		cs.mem_read   = 1'b0;
		cs.mem_to_reg = 1'b0;
		cs.mem_write  = 1'b0;
		cs.alu_src    = 1'b0;
		cs.reg_write  = 1'b0; // Unknown opcode writes nothing
		alu_class     = mips_pkg::CLS_ADD;
		case (instr.i.opcode)
			`OP_RTYPE: begin
				cs.reg_dst   = 1'b1;
				cs.reg_write = 1'b1;
				alu_class    = mips_pkg::CLS_FUNCT;
			end
			`OP_LW: begin
				cs.mem_read   = 1'b1;
				cs.mem_to_reg = 1'b1;
				cs.alu_src    = 1'b1; // Base plus offset
				cs.reg_write  = 1'b1;
			end
			`OP_SW: begin
				cs.mem_write = 1'b1;
				cs.alu_src   = 1'b1;
			end
			`OP_BEQ: begin
				cs.branch = 1'b1;
				alu_class = mips_pkg::CLS_SUB; // Equal when difference is zero
			end
			`OP_ADDI: begin
				cs.alu_src   = 1'b1;
				cs.reg_write = 1'b1;
			end
			default: ;
		endcase
	end

	// Function decoder
	always_comb begin
		case (alu_class)
			mips_pkg::CLS_SUB: cs.alu_op = mips_pkg::ALU_SUB;
			mips_pkg::CLS_FUNCT: begin
				case (instr.r.funct)
					`FN_ADD: cs.alu_op = mips_pkg::ALU_ADD;
					`FN_SUB: cs.alu_op = mips_pkg::ALU_SUB;
					`FN_AND: cs.alu_op = mips_pkg::ALU_AND;
					`FN_OR:  cs.alu_op = mips_pkg::ALU_OR;
					`FN_SLT: cs.alu_op = mips_pkg::ALU_SLT;
					default: cs.alu_op = mips_pkg::ALU_ADD;
				endcase
			end
			default: cs.alu_op = mips_pkg::ALU_ADD; // Address and addi
		endcase
	end

endmodule

// ==== logic/pc_unit.sv ====
`include "mips_defines.svh"

module pc_unit (
	input  logic                   clock,
	input  logic                   rst_n,
	input  logic                   branch_taken,
	input  logic [15:0]            imm,
	output logic [`DATA_WIDTH-1:0] pc
);

	logic [`DATA_WIDTH-1:0] pc_plus4;
	logic [`DATA_WIDTH-1:0] br_offset;
	logic [`DATA_WIDTH-1:0] br_target;
	logic [`DATA_WIDTH-1:0] pc_next;

	assign pc_plus4 = pc + `DATA_WIDTH'd4;

	// Word offset to byte offset
	assign br_offset = {{(`DATA_WIDTH-18){imm[15]}}, imm, 2'b00};
	assign br_target = pc_plus4 + br_offset; // Relative to the next instruction

	assign pc_next = branch_taken ? br_target : pc_plus4;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			pc <= '0; // Start of program
		end else begin
			pc <= pc_next;
		end
	end

endmodule

// ==== logic/regfile.sv ====
`include "mips_defines.svh"

module regfile (
	input  logic                       clock,
	input  logic                       rst_n,
	input  logic [`REG_ADDR_WIDTH-1:0] rs,
	input  logic [`REG_ADDR_WIDTH-1:0] rt,
	input  logic [`REG_ADDR_WIDTH-1:0] wr_addr,
	input  logic [`DATA_WIDTH-1:0]     wr_data,
	ctrl_if.dp                         cs,
	output logic [`DATA_WIDTH-1:0]     rd1,
	output logic [`DATA_WIDTH-1:0]     rd2
);

	localparam int NUM_REGS = 1 << `REG_ADDR_WIDTH;

	logic [`DATA_WIDTH-1:0] regs [NUM_REGS];

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (cs.reg_write && (wr_addr != '0)) begin
			regs[wr_addr] <= wr_data; // $zero never written
		end
	end

	// Combinational reads
	assign rd1 = (rs == '0) ? '0 : regs[rs];
	assign rd2 = (rt == '0) ? '0 : regs[rt];

endmodule

// ==== logic/i_mem.sv ====
`include "mips_defines.svh"

module i_mem #(
	parameter int DEPTH = `IMEM_DEPTH
) (
	input  logic                     clock,
	input  logic                     rst_n,
	input  logic                     we,
	input  logic [$clog2(DEPTH)-1:0] waddr, // Word index
	input  logic [`DATA_WIDTH-1:0]   wdata,
	input  logic [`DATA_WIDTH-1:0]   pc,
	output mips_pkg::instr_t         instr
);

	localparam int AW = $clog2(DEPTH);

	logic [`DATA_WIDTH-1:0] mem [DEPTH];

	// Loading only while the core sits in reset
	always_ff @(posedge clock) begin
		if (!rst_n && we) begin
			mem[waddr] <= wdata;
		end
	end

	assign instr = mem[pc[AW+1:2]]; // Byte address to word

endmodule

// ==== logic/d_mem.sv ====
`include "mips_defines.svh"

module d_mem #(
	parameter int DEPTH = `DMEM_DEPTH
) (
	input  logic                   clock,
	input  logic [`DATA_WIDTH-1:0] addr,  // Byte address from the ALU
	input  logic [`DATA_WIDTH-1:0] wdata,
	ctrl_if.dp                     cs,
	output logic [`DATA_WIDTH-1:0] rdata
);

	localparam int AW = $clog2(DEPTH);

	logic [`DATA_WIDTH-1:0] mem [DEPTH];
	logic [AW-1:0]          idx;

	// Aligned accesses only, low bits dropped
	assign idx = addr[AW+1:2];

	// sw
	always_ff @(posedge clock) begin
		if (cs.mem_write) begin
			mem[idx] <= wdata;
		end
	end

	// lw, zero when idle
	assign rdata = cs.mem_read ? mem[idx] : '0;

endmodule

// ==== logic/mips.sv ====
`include "mips_defines.svh"

module mips (
	input  logic                           clock,
	input  logic                           rst_n,
	input  logic                           imem_we,    // Program load strobe, reset only
	input  logic [$clog2(`IMEM_DEPTH)-1:0] imem_addr,  // Word index
	input  logic [`DATA_WIDTH-1:0]         imem_wdata,
	output logic [`DATA_WIDTH-1:0]         pc,
	output logic [`DATA_WIDTH-1:0]         alu_result,
	output logic [`DATA_WIDTH-1:0]         data_mem
);

	mips_pkg::instr_t instr;

	logic [`DATA_WIDTH-1:0]     rd1;
	logic [`DATA_WIDTH-1:0]     rd2;
	logic [`DATA_WIDTH-1:0]     imm_ext; // Sign-extended immediate
	logic [`DATA_WIDTH-1:0]     alu_b;
	logic [`DATA_WIDTH-1:0]     wb_data;
	logic [`REG_ADDR_WIDTH-1:0] wr_addr;
	logic                       zero;
	logic                       branch_taken;

	ctrl_if cs ();

	// Fetch
	pc_unit mips_pc (
		.clock        (clock),
		.rst_n        (rst_n),
		.branch_taken (branch_taken),
		.imm          (instr.i.imm),
		.pc           (pc)
	);

	i_mem #(.DEPTH(`IMEM_DEPTH)) mips_i_mem (
		.clock (clock),
		.rst_n (rst_n),
		.we    (imem_we),
		.waddr (imem_addr),
		.wdata (imem_wdata),
		.pc    (pc),
		.instr (instr)
	);

	// Decode
	control mips_control (
		.instr (instr),
		.cs    (cs.ctrl)
	);

	assign wr_addr = cs.reg_dst ? instr.r.rd : instr.i.rt; // rd for R-type
	assign wb_data = cs.mem_to_reg ? data_mem : alu_result; // lw writes memory word

	regfile mips_regfile (
		.clock   (clock),
		.rst_n   (rst_n),
		.rs      (instr.r.rs),
		.rt      (instr.r.rt),
		.wr_addr (wr_addr),
		.wr_data (wb_data),
		.cs      (cs.dp),
		.rd1     (rd1),
		.rd2     (rd2)
	);

	// Execute
	assign imm_ext = {{(`DATA_WIDTH-16){instr.i.imm[15]}}, instr.i.imm};
	assign alu_b   = cs.alu_src ? imm_ext : rd2;

	alu mips_alu (
		.a      (rd1),
		.b      (alu_b),
		.cs     (cs.dp),
		.result (alu_result),
		.zero   (zero)
	);

	assign branch_taken = cs.branch & zero; // beq with equal operands

	// Memory
	d_mem #(.DEPTH(`DMEM_DEPTH)) mips_d_mem (
		.clock (clock),
		.addr  (alu_result),
		.wdata (rd2), // sw stores rt
		.cs    (cs.dp),
		.rdata (data_mem)
	);

endmodule

// ==== testbench/mips_assert.sv ====
`include "mips_defines.svh"

module mips_assert (
	input logic                   clock,
	input logic                   rst_n,
	input logic [`DATA_WIDTH-1:0] pc,
	input logic [`DATA_WIDTH-1:0] instr // Raw instruction word
);
	timeunit 1ns;
	timeprecision 1ps;

	logic [`DATA_WIDTH-1:0] br_target;
	int unsigned            fail_count = 0; // Watched by the testbench

	// Where a taken beq in this cycle would land
	assign br_target = pc + 32'd4 + {{14{instr[15]}}, instr[15:0], 2'b00};

	pc_aligned: assert property (@(posedge clock) pc[1:0] == 2'b00)
		else begin
			fail_count++;
			$error("pc is not word aligned: %h", pc);
		end

	// Synchronous reset clears pc by the next edge
	pc_reset: assert property (@(posedge clock) !rst_n |=> pc == '0)
		else begin
			fail_count++;
			$error("pc not zero in the cycle after reset");
		end

	pc_next: assert property (@(posedge clock)
		$past(rst_n) |-> (pc == $past(pc) + 32'd4) || (pc == $past(br_target)))
		else begin
			fail_count++;
			$error("pc %h is neither pc plus four nor a branch target", pc);
		end

endmodule

bind mips mips_assert pc_checks (
	.clock (clock),
	.rst_n (rst_n),
	.pc    (pc),
	.instr (instr)
);

// ==== testbench/mips_tb.sv ====
`include "mips_defines.svh"

module mips_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD   = 100;
	localparam int DRIVE_DELAY  = 5;  // After the rising edge
	localparam int RESET_CYCLES = 3;
	localparam int IAW          = $clog2(`IMEM_DEPTH);
	// One checked cycle per program word
	localparam int PROGRAM_CYCLES  = 4 + 9 + 4 + 6 + 9;
	localparam int NUM_TESTS       = 5;
	localparam int WATCHDOG_CYCLES = 2 * PROGRAM_CYCLES + NUM_TESTS * (RESET_CYCLES + 2) + 20;

	logic                   clock;
	logic                   rst_n;
	logic                   imem_we;
	logic [IAW-1:0]         imem_addr;
	logic [`DATA_WIDTH-1:0] imem_wdata;
	logic [`DATA_WIDTH-1:0] pc;
	logic [`DATA_WIDTH-1:0] alu_result;
	logic [`DATA_WIDTH-1:0] data_mem;

	// Reference model state
	logic [31:0] prog [$];
	logic [31:0] regs_m [32];
	logic [31:0] mem_m [int]; // Keyed by word index
	logic [31:0] pc_m;
	int          seed;

	mips DUT (
		.clock      (clock),
		.rst_n      (rst_n),
		.imem_we    (imem_we),
		.imem_addr  (imem_addr),
		.imem_wdata (imem_wdata),
		.pc         (pc),
		.alu_result (alu_result),
		.data_mem   (data_mem)
	);

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Simulation failed");
		$fatal(1, "Watchdog expired before the tests finished");
	end

	// Bound pc checks count their failures
	initial begin
		wait (DUT.pc_checks.fail_count != 0);
		$display("Simulation failed");
		$fatal(1, "A bound pc assertion failed");
	end

	function automatic logic [31:0] rtype_word(input logic [5:0] funct,
		input logic [4:0] rd, input logic [4:0] rs, input logic [4:0] rt);
		return {`OP_RTYPE, rs, rt, rd, 5'd0, funct};
	endfunction

	function automatic logic [31:0] itype_word(input logic [5:0] op,
		input logic [4:0] rt, input logic [4:0] rs, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic abort_run();
		$display("Simulation failed");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic report_mismatch(input string name, input string what,
		input logic [31:0] exp, input logic [31:0] act);
		$display("[ERROR] %s: %s expected %h actual %h", name, what, exp, act);
		abort_run();
	endtask

	// Hold reset, write prog into instruction memory, clear the model, release
	task automatic load_program();
		@(posedge clock);
		#DRIVE_DELAY;
		rst_n = 1'b0;
		foreach (prog[i]) begin
			imem_we    = 1'b1;
			imem_addr  = IAW'(i);
			imem_wdata = prog[i];
			@(posedge clock);
			#DRIVE_DELAY;
		end
		imem_we = 1'b0;
		repeat (RESET_CYCLES) begin
			@(posedge clock);
			#DRIVE_DELAY;
		end
		foreach (regs_m[i]) regs_m[i] = '0;
		pc_m  = '0;
		rst_n = 1'b1;
	endtask

	// Compare one cycle against the model, then retire the instruction in the model
	task automatic check_cycle(input string name);
		logic [31:0] ins;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm_ext;
		logic [31:0] exp_alu;
		logic [31:0] exp_dm;
		logic [31:0] next_pc;
		logic [5:0]  op;
		int          widx;
		widx = int'(pc_m >> 2);
		if (widx >= prog.size()) begin
			$display("%s: model pc %h ran past the end of the program", name, pc_m);
			abort_run();
		end
		ins     = prog[widx];
		op      = ins[31:26];
		imm_ext = {{16{ins[15]}}, ins[15:0]};
		a       = regs_m[ins[25:21]];
		b       = (op == `OP_RTYPE || op == `OP_BEQ) ? regs_m[ins[20:16]] : imm_ext;
		next_pc = pc_m + 32'd4;
		exp_alu = a + b; // Address, addi
		exp_dm  = '0;    // Read port idles low
		case (op)
			`OP_RTYPE: begin
				case (ins[5:0])
					`FN_SUB: exp_alu = a - b;
					`FN_AND: exp_alu = a & b;
					`FN_OR:  exp_alu = a | b;
					`FN_SLT: exp_alu = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					default: exp_alu = a + b;
				endcase
			end
			`OP_LW: exp_dm = mem_m[int'(exp_alu >> 2)];
			`OP_BEQ: begin
				exp_alu = a - b;
				if (a == b) next_pc = pc_m + 32'd4 + {imm_ext[29:0], 2'b00};
			end
			default: ;
		endcase
		assert (pc == pc_m) else report_mismatch(name, "pc", pc_m, pc);
		assert (alu_result == exp_alu)
			else report_mismatch(name, "alu_result", exp_alu, alu_result);
		assert (data_mem == exp_dm)
			else report_mismatch(name, "data_mem", exp_dm, data_mem);
		// Write back with $zero held at zero
		if (op == `OP_RTYPE && ins[15:11] != 5'd0) regs_m[ins[15:11]] = exp_alu;
		if ((op == `OP_ADDI || op == `OP_LW) && ins[20:16] != 5'd0) begin
			regs_m[ins[20:16]] = (op == `OP_LW) ? exp_dm : exp_alu;
		end
		if (op == `OP_SW) mem_m[int'(exp_alu >> 2)] = regs_m[ins[20:16]];
		pc_m = next_pc;
	endtask

	task automatic run_program(input string name, input int cycles);
		load_program();
		repeat (cycles) begin
			@(negedge clock); // Combinational outputs settled
			check_cycle(name);
		end
		$display("%s: %0d cycles checked", name, cycles);
	endtask

	task automatic pc_advance_test();
		prog.delete();
		prog.push_back(itype_word(`OP_ADDI, 5'd1, 5'd0, 16'd5));
		prog.push_back(itype_word(`OP_ADDI, 5'd2, 5'd1, -16'sd3));
		prog.push_back(itype_word(`OP_ADDI, 5'd3, 5'd2, 16'd7));
		prog.push_back(itype_word(`OP_ADDI, 5'd4, 5'd0, 16'd1));
		run_program("pc_advance", 4);
	endtask

	task automatic alu_ops_test();
		logic [15:0] op_a;
		logic [15:0] op_b;
		op_a = 16'($random(seed)); // Sign extended by addi
		op_b = 16'($random(seed));
		prog.delete();
		prog.push_back(itype_word(`OP_ADDI, 5'd1, 5'd0, op_a));
		prog.push_back(itype_word(`OP_ADDI, 5'd2, 5'd0, op_b));
		prog.push_back(rtype_word(`FN_ADD, 5'd3, 5'd1, 5'd2));
		prog.push_back(rtype_word(`FN_SUB, 5'd4, 5'd1, 5'd2));
		prog.push_back(rtype_word(`FN_AND, 5'd5, 5'd1, 5'd2));
		prog.push_back(rtype_word(`FN_OR, 5'd6, 5'd3, 5'd4));  // Reuses earlier results
		prog.push_back(rtype_word(`FN_SLT, 5'd7, 5'd1, 5'd2));
		prog.push_back(rtype_word(`FN_SLT, 5'd8, 5'd2, 5'd1));
		prog.push_back(rtype_word(`FN_SUB, 5'd9, 5'd7, 5'd8));
		run_program("alu_ops", 9);
	endtask

	task automatic zero_reg_test();
		prog.delete();
		prog.push_back(itype_word(`OP_ADDI, 5'd0, 5'd0, 16'd99)); // Dropped
		prog.push_back(itype_word(`OP_ADDI, 5'd1, 5'd0, 16'd12));
		prog.push_back(rtype_word(`FN_ADD, 5'd2, 5'd0, 5'd1));
		prog.push_back(rtype_word(`FN_ADD, 5'd3, 5'd0, 5'd0));
		run_program("zero_reg", 4);
	endtask

	task automatic load_store_test();
		logic [15:0] value;
		value = 16'($random(seed));
		prog.delete();
		prog.push_back(itype_word(`OP_ADDI, 5'd1, 5'd0, value));
		prog.push_back(itype_word(`OP_ADDI, 5'd2, 5'd0, 16'd8));
		prog.push_back(itype_word(`OP_SW, 5'd1, 5'd2, 16'd12)); // Byte address 20
		prog.push_back(itype_word(`OP_ADDI, 5'd3, 5'd0, 16'd4));
		prog.push_back(itype_word(`OP_LW, 5'd4, 5'd3, 16'd16)); // Same word from another base
		prog.push_back(rtype_word(`FN_ADD, 5'd5, 5'd4, 5'd1));
		run_program("load_store", 6);
	endtask

	// Path 0, 4, 8, 20, 24, 28, 12, 16, 32
	task automatic branch_test();
		prog.delete();
		prog.push_back(itype_word(`OP_ADDI, 5'd1, 5'd0, 16'd3));
		prog.push_back(itype_word(`OP_ADDI, 5'd2, 5'd0, 16'd3));
		prog.push_back(itype_word(`OP_BEQ, 5'd2, 5'd1, 16'd2));    // Taken to 20
		prog.push_back(itype_word(`OP_ADDI, 5'd3, 5'd0, 16'd1));
		prog.push_back(itype_word(`OP_BEQ, 5'd0, 5'd0, 16'd3));    // Taken to 32
		prog.push_back(itype_word(`OP_ADDI, 5'd4, 5'd0, 16'd7));
		prog.push_back(itype_word(`OP_BEQ, 5'd4, 5'd1, 16'd1));    // Falls through
		prog.push_back(itype_word(`OP_BEQ, 5'd0, 5'd0, -16'sd5));  // Back to 12
		prog.push_back(rtype_word(`FN_ADD, 5'd5, 5'd3, 5'd4));
		run_program("branch", 9);
	endtask

	initial begin
		rst_n      = 1'b0;
		imem_we    = 1'b0;
		imem_addr  = '0;
		imem_wdata = '0;
		seed       = 32'h4418;
		pc_advance_test();
		alu_ops_test();
		zero_reg_test();
		load_store_test();
		branch_test();
		$display("Simulation passed");
		$finish;
	end

endmodule

// ==== build.f ====
+incdir+include
logic/mips_pkg.sv
logic/ctrl_if.sv
logic/alu.sv
logic/control.sv
logic/pc_unit.sv
logic/regfile.sv
logic/i_mem.sv
logic/d_mem.sv
logic/mips.sv
testbench/mips_assert.sv
testbench/mips_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the single-cycle MIPS testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps --top-module mips_tb -f build.f -o mips_sim
./obj_dir/mips_sim | tee sim.log

if grep -q "^Simulation passed$" sim.log; then
	exit 0
fi
echo "run.sh: pass message not found in sim.log"
exit 1
